/* sim.f */
src/slot_pkg.sv
src/primary_slot_reg.sv
src/sub_slot_select.sv
src/memory_map.sv
src/slot_system.sv
sim/slot_system_props.sv
sim/tb_slot_system.sv

/* sim/slot_system_props.sv */
/*
	Concurrent assertions on the slot system outputs, bound into the top level.
*/
module slot_system_props (
	input	clk42m,
	input	ff_reset_n,
	input	bus_req,
	input	mem_req,
	input	mem_wr,
	input	rdata_en
);
	timeunit 1ns;
	timeprecision 100ps;
	import slot_pkg::*;

	// One kind of response per request
	a_exclusive: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!(mem_req && rdata_en)) else $error("mem_req and rdata_en high together");

	a_no_request: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!bus_req |=> !mem_req && !rdata_en) else $error("Output without a request");

	a_reset: assert property (@(posedge clk42m)
		!ff_reset_n |=> !mem_req && !rdata_en) else $error("Output active after reset");

	a_wr_with_req: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		mem_wr |-> mem_req) else $error("mem_wr high without mem_req");

endmodule

bind slot_system slot_system_props u_slot_system_props (
	.clk42m(clk42m), .ff_reset_n(ff_reset_n), .bus_req(bus_req),
	.mem_req(mem_req), .mem_wr(mem_wr), .rdata_en(rdata_en)
);

/* sim/tb_slot_system.sv */
/*
	Testbench of the slot system. Directed register and map sequences, then a
	long LFSR driven mix with a request every cycle, checked against a model.
*/
module tb_slot_system;
	timeunit 1ns;
	timeprecision 100ps;
	import slot_pkg::*;

	localparam int			CLK_PERIOD		= 10;			// ns
	localparam int			NUM_DIRECTED	= 40;			// Reset and directed cycles, upper bound
	localparam int			NUM_RANDOM		= 3000;
	localparam int			NUM_REQ			= NUM_DIRECTED + NUM_RANDOM;
	localparam logic [3:0]	EXP_MASK		= 4'b1001;		// Same as the DUT default

	logic		clk42m;
	logic		ff_reset_n;
	logic		bus_req;
	logic		bus_io;
	logic		bus_wr;
	addr_t		bus_addr;
	data_t		bus_wdata;
	logic		mem_req;
	logic		mem_wr;
	mem_addr_t	mem_address;
	logic		rdata_en;
	data_t		rdata;

	logic [31:0]	lfsr_state = 32'hec90_b16b;
	data_t			m_prim;							// Model of port A8h
	data_t			m_sec [0:3];					// Model of the FFFFh registers
	logic			exp_mem_req, exp_mem_wr, exp_rdata_en;
	mem_addr_t		exp_mem_address;
	data_t			exp_rdata;

	slot_system u_slot_system (
		.clk42m(clk42m), .ff_reset_n(ff_reset_n), .bus_req(bus_req), .bus_io(bus_io),
		.bus_wr(bus_wr), .bus_addr(bus_addr), .bus_wdata(bus_wdata), .mem_req(mem_req),
		.mem_wr(mem_wr), .mem_address(mem_address), .rdata_en(rdata_en), .rdata(rdata)
	);

	initial begin
		clk42m = 1'b0;
		forever #(CLK_PERIOD / 2) clk42m = ~clk42m;
	end

	initial begin
		#((NUM_REQ + 20) * CLK_PERIOD);
		$display("ERROR: watchdog expired before the test sequence completed");
		$display("Simulation finished: FAIL");
		$fatal(1, "Timeout");
	end

	// --------------------------------------------------------------------
	// Random numbers, taps 32 22 2 1
	// --------------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);		// One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s got %0h expected %0h at %0t", name, got, exp, $time);
			$display("Simulation finished: FAIL");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic check_outputs();
		check_value("mem_req", mem_req, exp_mem_req);
		check_value("mem_wr", mem_wr, exp_mem_wr);
		check_value("rdata_en", rdata_en, exp_rdata_en);
		if (exp_mem_req) check_value("mem_address", mem_address, exp_mem_address);
		if (exp_rdata_en) check_value("rdata", rdata, exp_rdata);
	endtask

	// --------------------------------------------------------------------
	// Reference model, registers as they were before the request
	// --------------------------------------------------------------------
	task automatic predict(input logic req, input logic io, input logic wr,
						   input addr_t addr, input data_t wdata);
		logic [1:0]	page;
		slot_t		pslot;
		slot_t		sub;
		logic		expanded;
		int			region;
		int			page_bits;
		exp_mem_req		= 1'b0;
		exp_mem_wr		= 1'b0;
		exp_rdata_en	= 1'b0;
		page			= addr[15:14];
		pslot			= m_prim[2 * page +: 2];
		expanded		= EXP_MASK[pslot];
		sub				= expanded ? m_sec[pslot][2 * page +: 2] : 2'd0;	// Plain slot uses entry 0
		region			= int'(pslot) * 4 + int'(sub);
		if (!req) begin
			exp_rdata_en = 1'b0;					// Idle cycle
		end
		else if (io) begin
			if (addr[7:0] == PPI_PORT_A && wr) m_prim = wdata;
			else if (addr[7:0] == PPI_PORT_A) begin
				exp_rdata_en	= 1'b1;
				exp_rdata		= m_prim;
			end
		end
		else if (addr == SUBSLOT_REG_ADDR && expanded) begin
			if (wr) m_sec[pslot] = wdata;
			else begin
				exp_rdata_en	= 1'b1;
				exp_rdata		= ~m_sec[pslot];	// Inverted readback
			end
		end
		else if (REGION_PAGES[region][page]) begin
			if (!wr || REGION_WRITABLE[region]) begin
				exp_mem_req		= 1'b1;
				exp_mem_wr		= wr;
				page_bits		= int'(addr[15:13]) % (1 << REGION_BANK_BITS[region]);
				exp_mem_address	= {REGION_BANK_BASE[region] + bank_t'(page_bits), addr[12:0]};
			end
		end
		else if (!wr) begin
			exp_rdata_en	= 1'b1;
			exp_rdata		= UNMAPPED_DATA;
		end
	endtask

	// Check the previous request, then drive the next one
	task automatic bus_cycle(input logic req, input logic io, input logic wr,
							 input addr_t addr, input data_t wdata);
		@(negedge clk42m);
		check_outputs();
		predict(req, io, wr, addr, wdata);
		bus_req		= req;
		bus_io		= io;
		bus_wr		= wr;
		bus_addr	= addr;
		bus_wdata	= wdata;
	endtask

	task automatic random_request();
		logic [2:0]	kind;
		logic		wr;
		logic		b;
		addr_t		addr;
		data_t		wdata;
		kind	= 3'(rand_bits(3));
		wr		= 1'(rand_bits(1));
		addr	= addr_t'(rand_bits(16));
		wdata	= data_t'(rand_bits(8));
		if (1'(rand_bits(1))) begin
			for (int f = 0; f < 4; f++) begin
				b = 1'(rand_bits(1));
				wdata[2 * f +: 2] = {b, b};			// Fields of slot 0 or 3
			end
		end
		case (kind)
			3'd0, 3'd1:	bus_cycle(1'b1, 1'b1, wr, {addr[15:8], PPI_PORT_A}, wdata);
			3'd2, 3'd3:	bus_cycle(1'b1, 1'b0, wr, SUBSLOT_REG_ADDR, wdata);
			3'd4:		bus_cycle(1'b1, 1'b1, wr, addr, wdata);		// Other ports
			default:	bus_cycle(1'b1, 1'b0, wr, addr, wdata);
		endcase
	endtask

	// --------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------
	initial begin
		{bus_req, bus_io, bus_wr, bus_addr, bus_wdata} = '0;
		{exp_mem_req, exp_mem_wr, exp_rdata_en, exp_mem_address, exp_rdata} = '0;
		m_prim		= '0;
		m_sec		= '{default: '0};
		ff_reset_n	= 1'b0;
		repeat (3) @(posedge clk42m);
		@(negedge clk42m);
		ff_reset_n	= 1'b1;
		bus_cycle(1'b1, 1'b1, 1'b1, 16'h00A8, 8'hC0);	// Page 3 on slot 3
		bus_cycle(1'b1, 1'b1, 1'b0, 16'h00A8, 8'h00);
		bus_cycle(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b1, 16'hFFFF, 8'h5A);	// Slot 3 secondary
		bus_cycle(1'b1, 1'b0, 1'b0, 16'hFFFF, 8'h00);
		bus_cycle(1'b1, 1'b1, 1'b1, 16'h00A8, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b1, 16'hFFFF, 8'h1B);	// Slot 0 secondary
		bus_cycle(1'b1, 1'b0, 1'b0, 16'hFFFF, 8'h00);
		bus_cycle(1'b1, 1'b1, 1'b1, 16'h00A8, 8'h40);	// Page 3 on slot 1
		bus_cycle(1'b1, 1'b0, 1'b1, 16'hFFFF, 8'h77);	// Plain slot, dropped
		bus_cycle(1'b1, 1'b0, 1'b0, 16'hFFFF, 8'h00);
		bus_cycle(1'b1, 1'b1, 1'b1, 16'h00A8, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b1, 16'hFFFF, 8'h0C);	// Page 1 on sub-slot 3
		bus_cycle(1'b1, 1'b0, 1'b0, 16'h1234, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b0, 16'h3000, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b0, 16'h6000, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b0, 16'h8000, 8'h00);	// Main ROM not in page 2
		bus_cycle(1'b1, 1'b1, 1'b1, 16'h00A8, 8'hFF);	// All pages on slot 3
		bus_cycle(1'b1, 1'b0, 1'b1, 16'hFFFF, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b1, 16'h4321, 8'h99);	// Mapper RAM write
		bus_cycle(1'b1, 1'b0, 1'b1, 16'hC000, 8'h66);
		bus_cycle(1'b1, 1'b1, 1'b1, 16'h00A8, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b1, 16'h0000, 8'h55);	// ROM write, dropped
		bus_cycle(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			random_request();
		end
		bus_cycle(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
		bus_cycle(1'b0, 1'b0, 1'b0, 16'h0000, 8'h00);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* src/memory_map.sv */
/*
	Memory map of the slot system.
	Looks up the region of the selected slot and sub-slot, forms the external
	address and enables, and muxes register read data. All outputs registered.
*/
module memory_map (
	input								clk42m,
	input								ff_reset_n,
	input								bus_req,
	input								bus_io,
	input								bus_wr,
	input	slot_pkg::addr_t			bus_addr,
	input	slot_pkg::slot_t			page_slot,		// Primary slot of the page
	input	slot_pkg::slot_t	[3:0]	sub_slot_all,	// One per primary slot
	input				[3:0]			sub_hit_all,
	input	slot_pkg::data_t	[3:0]	sub_rdata_all,
	input								prim_hit,		// A8h read
	input	slot_pkg::data_t			prim_rdata,
	output								mem_req,
	output								mem_wr,
	output	slot_pkg::mem_addr_t		mem_address,
	output								rdata_en,
	output	slot_pkg::data_t			rdata
);
	import slot_pkg::*;

	slot_t			w_sub;
	logic	[3:0]	w_region;			// {primary, sub}
	logic	[1:0]	w_page;
	logic			w_answers;
	logic			w_writable;
	logic	[2:0]	w_page_bits;
	bank_t			w_bank;
	logic			w_mem_access;
	logic			w_own_hit;
	data_t			w_own_rdata;
	logic			w_next_mem_req;
	logic			w_next_mem_wr;
	logic			w_next_rdata_en;
	data_t			w_next_rdata;

	logic			ff_mem_req;
	logic			ff_mem_wr;
	mem_addr_t		ff_mem_address;
	logic			ff_rdata_en;
	data_t			ff_rdata;

	// Mask for the low n address bits above A12
	function automatic logic [2:0] bank_mask(input logic [1:0] n);
		case (n)
			2'd0:		return 3'b000;
			2'd1:		return 3'b001;
			2'd2:		return 3'b011;
			default:	return 3'b111;
		endcase
	endfunction

	// --------------------------------------------------------------------
	// Region lookup
	// --------------------------------------------------------------------
	assign w_sub		= sub_slot_all[page_slot];
	assign w_region		= {page_slot, w_sub};
	assign w_page		= bus_addr[15:14];
	assign w_answers	= REGION_PAGES[w_region][w_page];
	assign w_writable	= REGION_WRITABLE[w_region];

	// Bank is base plus page bits from A13 upward
	assign w_page_bits	= bus_addr[15:13] & bank_mask(REGION_BANK_BITS[w_region]);
	assign w_bank		= REGION_BANK_BASE[w_region] + {7'd0, w_page_bits};

	assign w_mem_access	= bus_req && !bus_io;
	assign w_own_hit	= sub_hit_all[page_slot];		// FFFFh claimed by a selector
	assign w_own_rdata	= sub_rdata_all[page_slot];

	// --------------------------------------------------------------------
	// Access decision
	// --------------------------------------------------------------------
	always_comb begin
		w_next_mem_req	= 1'b0;
		w_next_mem_wr	= 1'b0;
		w_next_rdata_en	= 1'b0;
		w_next_rdata	= UNMAPPED_DATA;
		if (prim_hit) begin
			w_next_rdata_en	= 1'b1;
			w_next_rdata	= prim_rdata;
		end
		else if (w_mem_access && w_own_hit) begin
			if (!bus_wr) begin						// Register write gives no output
				w_next_rdata_en	= 1'b1;
				w_next_rdata	= w_own_rdata;
			end
		end
		else if (w_mem_access && w_answers) begin
			if (!bus_wr || w_writable) begin		// ROM writes dropped
				w_next_mem_req	= 1'b1;
				w_next_mem_wr	= bus_wr;
			end
		end
		else if (w_mem_access && !bus_wr) begin
			w_next_rdata_en	= 1'b1;					// Unmapped read returns FFh
		end
	end

	// --------------------------------------------------------------------
	// Output stage
	// --------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_mem_req	<= 1'b0;
			ff_mem_wr	<= 1'b0;
			ff_rdata_en	<= 1'b0;
		end
		else begin
			ff_mem_req	<= w_next_mem_req;
			ff_mem_wr	<= w_next_mem_wr;
			ff_rdata_en	<= w_next_rdata_en;
		end
	end

	always_ff @(posedge clk42m) begin
		if (w_next_mem_req) begin
			ff_mem_address <= {w_bank, bus_addr[12:0]};
		end
		if (w_next_rdata_en) begin
			ff_rdata <= w_next_rdata;
		end
	end

	assign mem_req		= ff_mem_req;
	assign mem_wr		= ff_mem_wr;
	assign mem_address	= ff_mem_address;
	assign rdata_en		= ff_rdata_en;
	assign rdata		= ff_rdata;

endmodule

/* src/primary_slot_reg.sv */
/*
	Primary slot register behind I/O port A8h.
	Gives the primary slot of the page addressed by the current bus request.
*/
module primary_slot_reg (
	input						clk42m,
	input						ff_reset_n,
	input						bus_req,		// One-cycle request strobe
	input						bus_io,			// I/O access
	input						bus_wr,			// Write access
	input	slot_pkg::addr_t	bus_addr,
	input	slot_pkg::data_t	bus_wdata,
	output	slot_pkg::slot_t	page_slot,		// Primary slot of current page
	output						prim_hit,		// I/O read of A8h
	output	slot_pkg::data_t	prim_rdata
);
	import slot_pkg::*;

	data_t			ff_prim_reg;		// Two bits per 16 KB page
	logic			w_port_sel;
	logic	[1:0]	w_page;
	logic	[2:0]	w_field_lsb;

	// --------------------------------------------------------------------
	// Port decode
	// --------------------------------------------------------------------
	assign w_port_sel	= bus_req && bus_io && (bus_addr[7:0] == PPI_PORT_A);	// Low byte only
	assign prim_hit		= w_port_sel && !bus_wr;

	// --------------------------------------------------------------------
	// Register
	// --------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_prim_reg <= '0;			// All pages on slot 0
		end
		else if (w_port_sel && bus_wr) begin
			ff_prim_reg <= bus_wdata;
		end
	end

	assign prim_rdata	= ff_prim_reg;

	// --------------------------------------------------------------------
	// Page to slot lookup
	// --------------------------------------------------------------------
	assign w_page		= bus_addr[15:14];
	assign w_field_lsb	= {w_page, 1'b0};			// 2 * page
	assign page_slot	= ff_prim_reg[w_field_lsb +: 2];

endmodule

/* src/slot_pkg.sv */
/*
	Shared types, bus constants and the memory map region table of the slot system.
	Every module and the testbench import this package.
*/
package slot_pkg;

	typedef logic [15:0]	addr_t;			// CPU address
	typedef logic [7:0]		data_t;			// Bus data byte
	typedef logic [9:0]		bank_t;			// 8 KB bank number
	typedef logic [22:0]	mem_addr_t;		// {bank, 13-bit offset}
	typedef logic [1:0]		slot_t;			// Slot or sub-slot number

	localparam logic [7:0]	PPI_PORT_A			= 8'hA8;	// Primary slot register port
	localparam addr_t		SUBSLOT_REG_ADDR	= 16'hFFFF;	// Secondary slot register
	localparam data_t		UNMAPPED_DATA		= 8'hFF;	// Open bus value

	// --------------------------------------------------------------------
	// Region table, indexed by primary slot * 4 + sub-slot
	// --------------------------------------------------------------------
	localparam bank_t REGION_BANK_BASE [0:15] = '{
		10'h010, 10'h118, 10'h09A, 10'h01C,		// Slot 0 ROMs
		10'h000, 10'h000, 10'h000, 10'h000,		// Slot 1 empty
		10'h000, 10'h000, 10'h000, 10'h000,		// Slot 2 empty
		10'h200, 10'h014, 10'h000, 10'h000		// Mapper RAM, sub-ROM, Nextor
	};

	// Number of address bits from A13 upward added to the base
	localparam logic [1:0] REGION_BANK_BITS [0:15] = '{
		2'd2, 2'd1, 2'd1, 2'd2,
		2'd0, 2'd0, 2'd0, 2'd0,
		2'd0, 2'd0, 2'd0, 2'd0,
		2'd3, 2'd2, 2'd3, 2'd0
	};

	// Bit n set when the region answers in page n
	localparam logic [3:0] REGION_PAGES [0:15] = '{
		4'b0011, 4'b0010, 4'b0010, 4'b0110,
		4'b0000, 4'b0000, 4'b0000, 4'b0000,
		4'b0000, 4'b0000, 4'b0000, 4'b0000,
		4'b1111, 4'b0011, 4'b0110, 4'b0000
	};

	localparam logic REGION_WRITABLE [0:15] = '{
		1'b0, 1'b0, 1'b0, 1'b0,
		1'b0, 1'b0, 1'b0, 1'b0,
		1'b0, 1'b0, 1'b0, 1'b0,
		1'b1, 1'b0, 1'b0, 1'b0		// Only mapper RAM takes writes
	};

endpackage

/* src/slot_system.sv */
/*
	Top level of the slot selection and memory map core.
	Bus requests in, external memory requests and read data out one cycle later.
*/
module slot_system #(
	parameter logic [3:0] EXP_SLOT_MASK = 4'b1001	// Expanded primary slots
) (
	input							clk42m,
	input							ff_reset_n,
	input							bus_req,
	input							bus_io,
	input							bus_wr,
	input	slot_pkg::addr_t		bus_addr,
	input	slot_pkg::data_t		bus_wdata,
	output							mem_req,
	output							mem_wr,
	output	slot_pkg::mem_addr_t	mem_address,
	output							rdata_en,
	output	slot_pkg::data_t		rdata
);
	import slot_pkg::*;

	slot_t				w_page_slot;
	logic				w_prim_hit;
	data_t				w_prim_rdata;
	slot_t	[3:0]		w_sub_slot_all;
	logic	[3:0]		w_sub_hit_all;
	data_t	[3:0]		w_sub_rdata_all;

	// --------------------------------------------------------------------
	// Primary slot register
	// --------------------------------------------------------------------
	primary_slot_reg u_primary_slot_reg (
		.clk42m			( clk42m			),
		.ff_reset_n		( ff_reset_n		),
		.bus_req		( bus_req			),
		.bus_io			( bus_io			),
		.bus_wr			( bus_wr			),
		.bus_addr		( bus_addr			),
		.bus_wdata		( bus_wdata			),
		.page_slot		( w_page_slot		),
		.prim_hit		( w_prim_hit		),
		.prim_rdata		( w_prim_rdata		)
	);

	// --------------------------------------------------------------------
	// Secondary slot selectors, one per primary slot
	// --------------------------------------------------------------------
	for (genvar i = 0; i < 4; i++) begin : g_slot
		sub_slot_select #(
			.EXPANDED		( EXP_SLOT_MASK[i]	)
		) u_sub_slot_select (
			.clk42m			( clk42m			),
			.ff_reset_n		( ff_reset_n		),
			.bus_req		( bus_req			),
			.bus_io			( bus_io			),
			.bus_wr			( bus_wr			),
			.bus_addr		( bus_addr			),
			.bus_wdata		( bus_wdata			),
			.slot_selected	( w_page_slot == slot_t'(i)	),	// Live page compare
			.sub_slot		( w_sub_slot_all[i]	),
			.sub_hit		( w_sub_hit_all[i]	),
			.sub_rdata		( w_sub_rdata_all[i]	)
		);
	end

	// --------------------------------------------------------------------
	// Memory map and output stage
	// --------------------------------------------------------------------
	memory_map u_memory_map (
		.clk42m			( clk42m			),
		.ff_reset_n		( ff_reset_n		),
		.bus_req		( bus_req			),
		.bus_io			( bus_io			),
		.bus_wr			( bus_wr			),
		.bus_addr		( bus_addr			),
		.page_slot		( w_page_slot		),
		.sub_slot_all	( w_sub_slot_all	),
		.sub_hit_all	( w_sub_hit_all		),
		.sub_rdata_all	( w_sub_rdata_all	),
		.prim_hit		( w_prim_hit		),
		.prim_rdata		( w_prim_rdata		),
		.mem_req		( mem_req			),
		.mem_wr			( mem_wr			),
		.mem_address	( mem_address		),
		.rdata_en		( rdata_en			),
		.rdata			( rdata				)
	);

endmodule

/* src/sub_slot_select.sv */
/*
	Secondary slot selector of one primary slot.
	An expanded slot holds the FFFFh register, which reads back inverted.
	A plain slot holds no state and always reports sub-slot 0.
*/
module sub_slot_select #(
	parameter bit EXPANDED = 1'b0				// Slot is expanded
) (
	input						clk42m,
	input						ff_reset_n,
	input						bus_req,
	input						bus_io,
	input						bus_wr,
	input	slot_pkg::addr_t	bus_addr,
	input	slot_pkg::data_t	bus_wdata,
	input						slot_selected,	// Current page maps to this slot
	output	slot_pkg::slot_t	sub_slot,		// Sub-slot of current page
	output						sub_hit,		// This FFFFh access is ours
	output	slot_pkg::data_t	sub_rdata		// Inverted register value
);
	import slot_pkg::*;

	generate
		if (EXPANDED) begin : g_expanded
			data_t			ff_sub_reg;			// Two bits per page
			logic			w_reg_sel;
			logic	[2:0]	w_field_lsb;

			// ------------------------------------------------------------
			// FFFFh decode
			// ------------------------------------------------------------
			// Page 3 must point at this slot, else the access goes to memory
			assign w_reg_sel	= bus_req && !bus_io &&
								  (bus_addr == SUBSLOT_REG_ADDR) && slot_selected;

			always_ff @(posedge clk42m) begin
				if (!ff_reset_n) begin
					ff_sub_reg <= '0;
				end
				else if (w_reg_sel && bus_wr) begin
					ff_sub_reg <= bus_wdata;
				end
			end

			assign sub_hit		= w_reg_sel;		// Reads and writes both
			assign sub_rdata	= ~ff_sub_reg;		// MSX readback is inverted

			// ------------------------------------------------------------
			// Sub-slot of the current page
			// ------------------------------------------------------------
			assign w_field_lsb	= {bus_addr[15:14], 1'b0};
			assign sub_slot		= ff_sub_reg[w_field_lsb +: 2];
		end
		else begin : g_plain
			// No register here, the map uses table entry 0 of the slot
			assign sub_slot		= '0;
			assign sub_hit		= 1'b0;
			assign sub_rdata	= UNMAPPED_DATA;
		end
	endgenerate

endmodule
